/* src/dcache_cfg.svh */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// data word width in bits
`define DCACHE_DATA_WIDTH 32

// words in one cache line
`define DCACHE_LINE_WORDS 4

`define DCACHE_WAYS 4    // associativity

// sets per way, 4KB per way with 16-byte lines
`define DCACHE_SETS 256

`endif

/* src/dcache_pkg.sv */
`include "dcache_cfg.svh"

package dcache_pkg;

    localparam int unsigned BYTES_PER_WORD = `DCACHE_DATA_WIDTH / 8;
    localparam int unsigned OFFSET_W = $clog2(`DCACHE_LINE_WORDS * BYTES_PER_WORD);
    localparam int unsigned INDEX_W = $clog2(`DCACHE_SETS);
    localparam int unsigned TAG_W = 32 - INDEX_W - OFFSET_W;

    typedef logic [`DCACHE_DATA_WIDTH-1:0] word_t;
    typedef logic [TAG_W-1:0] tag_t;        // addr[31:12]
    typedef logic [INDEX_W-1:0] index_t;    // addr[11:4]
    typedef logic [OFFSET_W-1:0] offset_t;  // addr[3:0]

    // word 0 sits in the low bits
    typedef logic [`DCACHE_LINE_WORDS-1:0][`DCACHE_DATA_WIDTH-1:0] line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    typedef logic [`DCACHE_WAYS-1:0] way_mask_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    // byte address of a line with the offset dropped
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } line_addr_t;

endpackage

/* src/lsu_pkg.sv */
package lsu_pkg;

    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } op_e;

    // encoded as {sign, size}, size 0 byte, 1 half, 2 word
    typedef enum logic [2:0] {
        LT_LBU = 3'b000,
        LT_LHU = 3'b001,
        LT_LW  = 3'b010,
        LT_LB  = 3'b100,
        LT_LH  = 3'b101
    } load_type_e;

endpackage

/* src/dcache_array.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_array #(
    parameter type dtype = logic,
    parameter int unsigned DEPTH = `DCACHE_SETS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::index_t    addr,
    input  dcache_pkg::way_mask_t we,
    input  dtype                  wdata,
    output dtype                  rdata [`DCACHE_WAYS]
);

    for (genvar w = 0; w < `DCACHE_WAYS; w++) begin : g_way
        dtype mem [DEPTH];

        always_ff @(posedge clk) begin
            if (rst) begin
                for (int i = 0; i < DEPTH; i++) begin
                    mem[i] <= '0;
                end
                rdata[w] <= '0;
            end else begin
                if (we[w]) begin
                    mem[addr] <= wdata;
                end
                rdata[w] <= mem[addr];  // old data on a same-cycle write
            end
        end
    end

endmodule

/* src/plru_table.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module plru_table (
    input  logic                  clk,
    input  logic                  rst,
    input  dcache_pkg::index_t    index,
    input  dcache_pkg::way_mask_t access,
    output dcache_pkg::way_t      victim
);

    // bit 0 root, bit 1 picks in ways 0/1, bit 2 picks in ways 2/3
    logic [2:0] tree [`DCACHE_SETS];
    dcache_pkg::way_t touched;

    always_comb begin
        touched = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (access[w]) begin
                touched = dcache_pkg::way_t'(w);
            end
        end
    end

    assign victim = {tree[index][0], tree[index][0] ? tree[index][2] : tree[index][1]};

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < `DCACHE_SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (|access) begin
            tree[index][0] <= ~touched[1];  // point to the other half
            if (touched[1]) begin
                tree[index][2] <= ~touched[0];
            end else begin
                tree[index][1] <= ~touched[0];
            end
        end
    end

endmodule

/* src/load_align.sv */
`timescale 1ns/1ps

module load_align (
    input  dcache_pkg::word_t     word,
    input  dcache_pkg::offset_t   offset,
    input  lsu_pkg::load_type_e   load_type,
    output dcache_pkg::word_t     rdata
);

    logic [15:0] half;
    logic [7:0]  byte_sel;

    assign half = offset[1] ? word[31:16] : word[15:0];

    always_comb begin
        case (offset[1:0])
            2'b00:   byte_sel = word[7:0];
            2'b01:   byte_sel = word[15:8];
            2'b10:   byte_sel = word[23:16];
            default: byte_sel = word[31:24];
        endcase
    end

    always_comb begin
        case (load_type)
            lsu_pkg::LT_LH:  rdata = {{16{half[15]}}, half};
            lsu_pkg::LT_LHU: rdata = {16'b0, half};
            lsu_pkg::LT_LB:  rdata = {{24{byte_sel[7]}}, byte_sel};
            lsu_pkg::LT_LBU: rdata = {24'b0, byte_sel};
            default:         rdata = word;  // LW
        endcase
    end

endmodule

/* src/dcache_ctrl.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  lsu_pkg::op_e                      req_op,
    input  logic [31:0]                       req_addr,
    input  logic [dcache_pkg::BYTES_PER_WORD-1:0] req_wstrb,
    input  dcache_pkg::word_t                 req_wdata,
    input  lsu_pkg::load_type_e               req_load_type,
    output logic                              resp_valid,
    input  logic                              resp_ready,
    output dcache_pkg::word_t                 resp_word,
    output dcache_pkg::offset_t               resp_offset,
    output lsu_pkg::load_type_e               resp_load_type,
    output dcache_pkg::index_t                arr_index,
    input  dcache_pkg::tagv_t                 tagv_rdata [`DCACHE_WAYS],
    output dcache_pkg::way_mask_t             tagv_we,
    output dcache_pkg::tagv_t                 tagv_wdata,
    input  dcache_pkg::line_t                 line_rdata [`DCACHE_WAYS],
    output dcache_pkg::way_mask_t             line_we,
    output dcache_pkg::line_t                 line_wdata,
    input  logic                              dirty_rdata [`DCACHE_WAYS],
    output dcache_pkg::way_mask_t             dirty_we,
    output logic                              dirty_wdata,
    output dcache_pkg::way_mask_t             plru_access,
    input  dcache_pkg::way_t                  victim,
    output logic                              mem_rd_valid,
    input  logic                              mem_rd_ready,
    output dcache_pkg::line_addr_t            mem_rd_addr,
    input  logic                              mem_rdata_valid,
    input  dcache_pkg::line_t                 mem_rdata,
    output logic                              mem_wr_valid,
    input  logic                              mem_wr_ready,
    output dcache_pkg::line_addr_t            mem_wr_addr,
    output dcache_pkg::line_t                 mem_wr_line
);

    typedef enum logic [2:0] {
        IDLE, LOOKUP, WRITEBACK, REFILL_REQ, REFILL_WAIT, REREAD
    } state_e;

    state_e state, state_next;

    // request register, payload only
    lsu_pkg::op_e                          r_op;
    dcache_pkg::tag_t                      r_tag;
    dcache_pkg::index_t                    r_index;
    dcache_pkg::offset_t                   r_offset;
    logic [dcache_pkg::BYTES_PER_WORD-1:0] r_wstrb;
    dcache_pkg::word_t                     r_wdata;
    lsu_pkg::load_type_e                   r_load_type;

    dcache_pkg::way_mask_t hit, victim_mask;
    dcache_pkg::way_t      hit_way;
    dcache_pkg::line_t     merged;
    logic [dcache_pkg::OFFSET_W-3:0] word_sel;
    logic resp_fire, refill_done;

    assign req_ready   = (state == IDLE);
    assign arr_index   = r_index;   // arrays keep re-reading the set in flight
    assign word_sel    = r_offset[dcache_pkg::OFFSET_W-1:2];
    assign victim_mask = dcache_pkg::way_mask_t'(1) << victim;
    assign refill_done = (state == REFILL_WAIT) && mem_rdata_valid;

    always_comb begin
        hit = '0;
        hit_way = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (tagv_rdata[w].valid && tagv_rdata[w].tag == r_tag) begin
                hit[w] = 1'b1;
                hit_way = dcache_pkg::way_t'(w);
            end
        end
    end

    assign resp_valid     = (state == LOOKUP) && (|hit);
    assign resp_fire      = resp_valid && resp_ready;
    assign resp_word      = (r_op == lsu_pkg::OP_STORE) ? '0 : line_rdata[hit_way][word_sel];
    assign resp_offset    = r_offset;
    assign resp_load_type = r_load_type;
    assign plru_access    = resp_fire ? hit : '0;

    // store bytes over the hit line
    always_comb begin
        merged = line_rdata[hit_way];
        for (int b = 0; b < dcache_pkg::BYTES_PER_WORD; b++) begin
            if (r_wstrb[b]) begin
                merged[word_sel][8*b +: 8] = r_wdata[8*b +: 8];
            end
        end
    end

    // refill writes the victim way, a store writes on its response
    assign tagv_we     = refill_done ? victim_mask : '0;
    assign tagv_wdata  = '{valid: 1'b1, tag: r_tag};
    assign line_we     = refill_done ? victim_mask :
                         (resp_fire && r_op == lsu_pkg::OP_STORE) ? hit : '0;
    assign line_wdata  = (state == REFILL_WAIT) ? mem_rdata : merged;
    assign dirty_we    = line_we;
    assign dirty_wdata = (state != REFILL_WAIT);

    assign mem_rd_valid = (state == REFILL_REQ);
    assign mem_rd_addr  = '{tag: r_tag, index: r_index};
    assign mem_wr_valid = (state == WRITEBACK);
    assign mem_wr_addr  = '{tag: tagv_rdata[victim].tag, index: r_index};
    assign mem_wr_line  = line_rdata[victim];

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            r_op        <= req_op;
            r_tag       <= req_addr[31 -: dcache_pkg::TAG_W];
            r_index     <= req_addr[dcache_pkg::OFFSET_W +: dcache_pkg::INDEX_W];
            r_offset    <= req_addr[dcache_pkg::OFFSET_W-1:0];
            r_wstrb     <= req_wstrb;
            r_wdata     <= req_wdata;
            r_load_type <= req_load_type;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:        if (req_valid) state_next = REREAD;
            REREAD:      state_next = LOOKUP;
            LOOKUP: begin
                if (|hit) begin
                    if (resp_ready) state_next = IDLE;
                end else if (dirty_rdata[victim]) begin
                    state_next = WRITEBACK;
                end else begin
                    state_next = REFILL_REQ;
                end
            end
            WRITEBACK:   if (mem_wr_ready) state_next = REFILL_REQ;
            REFILL_REQ:  if (mem_rd_ready) state_next = REFILL_WAIT;
            REFILL_WAIT: if (mem_rdata_valid) state_next = REREAD;
            default:     state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

endmodule

/* src/dcache_top.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module dcache_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              req_valid,
    output logic                              req_ready,
    input  lsu_pkg::op_e                      req_op,
    input  logic [31:0]                       req_addr,
    input  logic [dcache_pkg::BYTES_PER_WORD-1:0] req_wstrb,
    input  dcache_pkg::word_t                 req_wdata,
    input  lsu_pkg::load_type_e               req_load_type,
    output logic                              resp_valid,
    input  logic                              resp_ready,
    output dcache_pkg::word_t                 resp_rdata,
    output logic                              mem_rd_valid,
    input  logic                              mem_rd_ready,
    output dcache_pkg::line_addr_t            mem_rd_addr,
    input  logic                              mem_rdata_valid,
    input  dcache_pkg::line_t                 mem_rdata,
    output logic                              mem_wr_valid,
    input  logic                              mem_wr_ready,
    output dcache_pkg::line_addr_t            mem_wr_addr,
    output dcache_pkg::line_t                 mem_wr_line
);

    dcache_pkg::word_t     resp_word;
    dcache_pkg::offset_t   resp_offset;
    lsu_pkg::load_type_e   resp_load_type;
    dcache_pkg::index_t    arr_index;
    dcache_pkg::tagv_t     tagv_rdata [`DCACHE_WAYS];
    dcache_pkg::tagv_t     tagv_wdata;
    dcache_pkg::line_t     line_rdata [`DCACHE_WAYS];
    dcache_pkg::line_t     line_wdata;
    logic                  dirty_rdata [`DCACHE_WAYS];
    logic                  dirty_wdata;
    dcache_pkg::way_mask_t tagv_we, line_we, dirty_we, plru_access;
    dcache_pkg::way_t      victim;

    dcache_ctrl u_ctrl (.*);

    dcache_array #(.dtype(dcache_pkg::tagv_t)) u_tagv (
        .clk, .rst, .addr(arr_index), .we(tagv_we), .wdata(tagv_wdata), .rdata(tagv_rdata)
    );

    dcache_array #(.dtype(dcache_pkg::line_t)) u_line (
        .clk, .rst, .addr(arr_index), .we(line_we), .wdata(line_wdata), .rdata(line_rdata)
    );

    dcache_array #(.dtype(logic)) u_dirty (
        .clk, .rst, .addr(arr_index), .we(dirty_we), .wdata(dirty_wdata), .rdata(dirty_rdata)
    );

    plru_table u_plru (
        .clk, .rst, .index(arr_index), .access(plru_access), .victim(victim)
    );

    load_align u_align (
        .word(resp_word), .offset(resp_offset), .load_type(resp_load_type), .rdata(resp_rdata)
    );

endmodule

/* testbench/mem_model.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module mem_model #(
    parameter logic [31:0] FILL = 32'h5a3c_96e1
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   mem_rd_valid,
    output logic                   mem_rd_ready,
    input  dcache_pkg::line_addr_t mem_rd_addr,
    output logic                   mem_rdata_valid,
    output dcache_pkg::line_t      mem_rdata,
    input  logic                   mem_wr_valid,
    output logic                   mem_wr_ready,
    input  dcache_pkg::line_addr_t mem_wr_addr,
    input  dcache_pkg::line_t      mem_wr_line
);

    dcache_pkg::line_t      lines [logic [27:0]];  // written-back lines only
    dcache_pkg::line_addr_t rd_addr;
    logic                   returning;
    int unsigned            delay;
    integer                 seed;

    initial begin
        seed            = 32'hd229;
        mem_rd_ready    = 1'b0;
        mem_wr_ready    = 1'b0;
        mem_rdata_valid = 1'b0;
        mem_rdata       = '0;
    end

    // untouched words hold their byte address xor FILL
    function automatic dcache_pkg::line_t read_line(input dcache_pkg::line_addr_t a);
        dcache_pkg::line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int w = 0; w < `DCACHE_LINE_WORDS; w++) begin
            l[w] = {a, w[1:0], 2'b00} ^ FILL;
        end
        return l;
    endfunction

    function automatic int unsigned next_delay();
        return $unsigned($random(seed)) % 8;  // 0 to 7 cycles
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mem_rd_ready    <= 1'b0;
            mem_wr_ready    <= 1'b0;
            mem_rdata_valid <= 1'b0;
            mem_rdata       <= '0;
            returning       <= 1'b0;
            delay           <= next_delay();
        end else begin
            mem_rd_ready    <= 1'b0;
            mem_wr_ready    <= 1'b0;
            mem_rdata_valid <= 1'b0;
            if (mem_wr_valid && mem_wr_ready) begin
                lines[mem_wr_addr] = mem_wr_line;
                delay <= next_delay();
            end else if (mem_rd_valid && mem_rd_ready) begin
                rd_addr   <= mem_rd_addr;
                returning <= 1'b1;
                delay     <= next_delay();
            end else if (returning) begin
                if (delay == 0) begin
                    mem_rdata_valid <= 1'b1;
                    mem_rdata       <= read_line(rd_addr);
                    returning       <= 1'b0;
                    delay           <= next_delay();
                end else begin
                    delay <= delay - 1;
                end
            end else if (mem_wr_valid || mem_rd_valid) begin
                if (delay == 0) begin
                    mem_wr_ready <= mem_wr_valid;
                    mem_rd_ready <= mem_rd_valid && !mem_wr_valid;
                end else begin
                    delay <= delay - 1;
                end
            end
        end
    end

endmodule

/* testbench/tb_dcache.sv */
`timescale 1ns/1ps
`include "dcache_cfg.svh"

module tb_dcache;

    localparam logic [31:0] FILL = 32'h5a3c_96e1;
    localparam int N_REQ       = 77;  // requests over all tests
    localparam int WORST_MISS  = 40;  // writeback, refill and return delays plus lookups
    localparam int WORST_STALL = 8;   // longest resp_ready low run
    localparam int MAX_CYCLES  = 16 + N_REQ * (WORST_MISS + WORST_STALL);

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   req_valid, req_ready;
    lsu_pkg::op_e           req_op;
    logic [31:0]            req_addr;
    logic [3:0]             req_wstrb;
    dcache_pkg::word_t      req_wdata;
    lsu_pkg::load_type_e    req_load_type;
    logic                   resp_valid, resp_ready;
    dcache_pkg::word_t      resp_rdata;
    logic                   mem_rd_valid, mem_rd_ready, mem_rdata_valid;
    dcache_pkg::line_addr_t mem_rd_addr, mem_wr_addr;
    dcache_pkg::line_t      mem_rdata, mem_wr_line;
    logic                   mem_wr_valid, mem_wr_ready;

    integer                 seed;
    int                     cycle_count = 0;
    dcache_pkg::word_t      shadow [logic [29:0]];  // stored words by word address

    dcache_top dut0 (.*);
    mem_model #(.FILL(FILL)) u_mem (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == MAX_CYCLES) begin
            report_failure("run did not finish within the cycle limit");
        end
    end

    task automatic report_mismatch(input string name, input dcache_pkg::word_t exp,
                                   input dcache_pkg::word_t act);
        $display("** Error [%s] expected %08h, actual %08h", name, exp, act);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_failure(input string what);
        $display("** Error %s", what);
        $display("Test failures found");
        $fatal(1);
    endtask

    function automatic dcache_pkg::word_t expected_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) begin
            return shadow[addr[31:2]];
        end
        return {addr[31:2], 2'b00} ^ FILL;
    endfunction

    function automatic dcache_pkg::word_t extend_load(input dcache_pkg::word_t w,
                                                      input logic [3:0] off,
                                                      input lsu_pkg::load_type_e lt);
        dcache_pkg::word_t   shifted;
        logic signed [31:0]  s;
        shifted = w >> (8 * off[1:0]);  // wanted part down to bit 0
        case (lt)
            lsu_pkg::LT_LB:  s = $signed(shifted[7:0]);
            lsu_pkg::LT_LH:  s = $signed(shifted[15:0]);
            lsu_pkg::LT_LBU: s = {24'h0, shifted[7:0]};
            lsu_pkg::LT_LHU: s = {16'h0, shifted[15:0]};
            default:         s = w;
        endcase
        return s;
    endfunction

    task automatic issue_request(input lsu_pkg::op_e op, input logic [31:0] addr,
                                 input logic [3:0] strb, input dcache_pkg::word_t data,
                                 input lsu_pkg::load_type_e lt);
        @(posedge clk);
        req_valid     <= 1'b1;
        req_op        <= op;
        req_addr      <= addr;
        req_wstrb     <= strb;
        req_wdata     <= data;
        req_load_type <= lt;
        @(negedge clk);
        while (!req_ready) @(negedge clk);
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    // random resp_ready stretches when hold is set
    task automatic wait_response(input string name, input bit hold,
                                 output dcache_pkg::word_t data);
        dcache_pkg::word_t held;
        bit                seen;
        bit                done;
        int                stall;
        seen  = 1'b0;
        done  = 1'b0;
        stall = 0;
        while (!done) begin
            @(negedge clk);
            if (resp_valid) begin
                assert (!seen || resp_rdata == held) else report_mismatch(name, held, resp_rdata);
                assert (!req_ready) else report_failure("req_ready high while a response waits");
                if (resp_ready) begin
                    done = 1'b1;
                    data = resp_rdata;
                end
                seen = 1'b1;
                held = resp_rdata;
            end
            @(posedge clk);
            if (!done && hold && stall < WORST_STALL && ($random(seed) & 3) != 0) begin
                resp_ready <= 1'b0;
                stall++;
            end else begin
                resp_ready <= 1'b1;
                stall = 0;
            end
        end
    endtask

    task automatic check_load(input string name, input logic [31:0] addr,
                              input lsu_pkg::load_type_e lt, input bit hold);
        dcache_pkg::word_t exp;
        dcache_pkg::word_t got;
        exp = extend_load(expected_word(addr), addr[3:0], lt);
        issue_request(lsu_pkg::OP_LOAD, addr, 4'h0, '0, lt);
        wait_response(name, hold, got);
        assert (got == exp) else report_mismatch(name, exp, got);
    endtask

    task automatic store_word(input string name, input logic [31:0] addr,
                              input logic [3:0] strb, input dcache_pkg::word_t data,
                              input bit hold);
        dcache_pkg::word_t cur;
        dcache_pkg::word_t got;
        issue_request(lsu_pkg::OP_STORE, addr, strb, data, lsu_pkg::LT_LW);
        wait_response(name, hold, got);
        assert (got == '0) else report_mismatch(name, '0, got);
        cur = expected_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) cur[8*b +: 8] = data[8*b +: 8];
        end
        shadow[addr[31:2]] = cur;
    endtask

    task automatic cold_reads();
        logic [31:0] addr;
        for (int i = 0; i < 8; i++) begin
            addr = $random(seed);
            if (i % 2 == 0) begin
                addr[31:12] = '0;  // same tag as a cleared entry
            end
            addr[1:0] = 2'b00;
            check_load("cold_reads", addr, lsu_pkg::LT_LW, 1'b0);
        end
    endtask

    task automatic strobe_stores();
        logic [31:0]       addr;
        dcache_pkg::word_t data;
        for (int s = 0; s < 16; s++) begin
            addr = 32'h0000_2000 + s * 4;
            data = $random(seed);
            store_word("strobe_stores", addr, s[3:0], data, 1'b0);
            check_load("strobe_stores", addr, lsu_pkg::LT_LW, 1'b0);
        end
    endtask

    task automatic narrow_loads();
        logic [31:0] base;
        base = 32'h0000_3a40;
        store_word("narrow_loads", base, 4'hf, 32'h8001_7fff, 1'b0);  // mixed sign bytes
        for (int off = 0; off < 4; off++) begin
            check_load("narrow_loads", base + off, lsu_pkg::LT_LB, 1'b0);
            check_load("narrow_loads", base + off, lsu_pkg::LT_LBU, 1'b0);
        end
        for (int off = 0; off < 4; off += 2) begin
            check_load("narrow_loads", base + off, lsu_pkg::LT_LH, 1'b0);
            check_load("narrow_loads", base + off, lsu_pkg::LT_LHU, 1'b0);
        end
    endtask

    task automatic set_conflict();
        logic [31:0] addr;
        for (int k = 0; k < 6; k++) begin
            addr = 32'h0004_0058 + k * 32'h0000_1000;  // index 0x05, new tag each time
            store_word("set_conflict", addr, 4'hf, 32'hc0de_0000 + k, 1'b0);
        end
        for (int k = 0; k < 6; k++) begin
            addr = 32'h0004_0058 + k * 32'h0000_1000;
            check_load("set_conflict", addr, lsu_pkg::LT_LW, 1'b0);
        end
    endtask

    task automatic backpressure();
        logic [31:0]       addr;
        dcache_pkg::word_t data;
        for (int i = 0; i < 4; i++) begin
            addr = 32'h0010_0054 + i * 32'h0000_2000;  // same busy set as set_conflict
            data = $random(seed);
            store_word("backpressure", addr, 4'hf, data, 1'b1);
            store_word("backpressure", addr, 4'h6, ~data, 1'b1);
            check_load("backpressure", addr, lsu_pkg::LT_LW, 1'b1);
        end
    endtask

    initial begin
        seed          = 32'hd229;
        rst           = 1'b1;
        req_valid     = 1'b0;
        req_op        = lsu_pkg::OP_LOAD;
        req_addr      = '0;
        req_wstrb     = '0;
        req_wdata     = '0;
        req_load_type = lsu_pkg::LT_LW;
        resp_ready    = 1'b1;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        cold_reads();
        strobe_stores();
        narrow_loads();
        set_conflict();
        backpressure();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* dcache.f */
+incdir+src
src/dcache_pkg.sv
src/lsu_pkg.sv
src/dcache_array.sv
src/plru_table.sv
src/load_align.sv
src/dcache_ctrl.sv
src/dcache_top.sv
testbench/mem_model.sv
testbench/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

export_include_dirs:
  - src

sources:
  - src/dcache_pkg.sv
  - src/lsu_pkg.sv
  - src/dcache_array.sv
  - src/plru_table.sv
  - src/load_align.sv
  - src/dcache_ctrl.sv
  - src/dcache_top.sv
  - target: test
    files:
      - testbench/mem_model.sv
      - testbench/tb_dcache.sv
